/* Makefile */
TOP := tb_sm83_addr_irq

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sm83_addr_irq.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* hw/addr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sm83_macros.svh"

module addr_unit (
	input logic clk,
	input logic rst_n,
	input sm83_pkg::addr_op_t op,
	input sm83_pkg::byte_t data_in,
	input sm83_pkg::dout_sel_t dout_sel,
	output sm83_pkg::addr_t addr,
	output sm83_pkg::byte_t data_out,
	irq_bus_if.addr irq
);

	import sm83_pkg::*;

	addr_t pc_q; // Program counter
	addr_t sp_q; // Stack pointer
	addr_t addr_q; // Address bus register

	addr_t step_src; // Operand of the incrementer
	addr_t step_delta; // +1 or -1 in two's complement
	addr_t step_res;
	logic step_dec; // Decrement for push

	// One shared 16-bit step unit for PC and SP
	assign step_src = (op == ADDR_PC_FETCH) ? pc_q : sp_q;
	assign step_dec = (op == ADDR_SP_PUSH);
	assign step_delta = step_dec ? 16'hFFFF : 16'h0001;
	assign step_res = step_src + step_delta; // Wraps mod 65536

	assign irq.take = (op == ADDR_IRQ_JUMP);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= `SM83_RESET_PC;
			sp_q <= `SM83_RESET_SP;
			addr_q <= '0;
		end else begin
			case (op)
				ADDR_PC_FETCH: begin
					addr_q <= pc_q;
					pc_q <= step_res;
				end
				ADDR_SP_PUSH: begin
					// Predecrement, address shows the new SP
					sp_q <= step_res;
					addr_q <= step_res;
				end
				ADDR_SP_POP: begin
					addr_q <= sp_q; // Postincrement
					sp_q <= step_res;
				end
				ADDR_LOAD_PCL: begin
					pc_q[`SM83_LO_BYTE] <= data_in;
				end
				ADDR_LOAD_PCH: begin
					pc_q[`SM83_HI_BYTE] <= data_in;
				end
				ADDR_LOAD_SPL: begin
					sp_q[`SM83_LO_BYTE] <= data_in;
				end
				ADDR_LOAD_SPH: begin
					sp_q[`SM83_HI_BYTE] <= data_in;
				end
				ADDR_IRQ_JUMP: begin
					pc_q <= irq.vector; // Vector of the acked source
				end
				default: begin
					pc_q <= pc_q;
				end
			endcase
		end
	end

	assign addr = addr_q;

	// Readback onto the data bus
	always_comb begin
		case (dout_sel)
			DOUT_PCL: data_out = pc_q[`SM83_LO_BYTE];
			DOUT_PCH: data_out = pc_q[`SM83_HI_BYTE];
			DOUT_SPL: data_out = sp_q[`SM83_LO_BYTE];
			DOUT_SPH: data_out = sp_q[`SM83_HI_BYTE];
			DOUT_IE: data_out = irq.ie_q;
			default: data_out = '0; // Unused select codes
		endcase
	end

endmodule

`default_nettype wire

/* hw/irq_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sm83_macros.svh"

interface irq_bus_if;

	sm83_pkg::irq_mask_t pending; // IF & IE
	sm83_pkg::byte_t ie_q; // IE contents for readback
	sm83_pkg::irq_mask_t ack; // One-hot winner
	sm83_pkg::addr_t vector; // Jump target of the winner
	logic take; // Jump taken this cycle

	modport flags (
		output pending,
		output ie_q,
		input ack,
		input take
	);

	modport dispatch (input pending, output ack, output vector);

	modport addr (input vector, input ie_q, output take);

endinterface

`default_nettype wire

/* hw/irq_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sm83_macros.svh"

module irq_dispatch (
	input logic ime,
	input logic irq_enable,
	output logic irq_pending,
	output sm83_pkg::irq_mask_t irq_ack,
	irq_bus_if.dispatch irq
);

	import sm83_pkg::*;

	localparam int IDX_W = $clog2(`SM83_IRQ_LINES);

	logic grant_en; // ime and dispatch enable
	logic found;
	irq_mask_t grant; // Lowest pending bit, one-hot
	logic [IDX_W-1:0] win_idx; // Source number of the winner

	assign grant_en = ime & irq_enable;

	// Fixed priority, source 0 first
	always_comb begin
		grant = '0;
		win_idx = '0;
		found = 1'b0;
		for (int i = 0; i < `SM83_IRQ_LINES; i++) begin
			if (grant_en && !found && irq.pending[i]) begin
				grant[i] = 1'b1;
				win_idx = IDX_W'(i);
				found = 1'b1;
			end
		end
	end

	// win_idx stays zero without a winner, so this falls back to BASE
	assign irq.vector = `SM83_VECTOR_BASE + addr_t'(win_idx) * `SM83_VECTOR_STRIDE;
	assign irq.ack = grant;

	assign irq_ack = grant;
	assign irq_pending = |irq.pending; // Independent of ime

endmodule

`default_nettype wire

/* hw/irq_flags.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sm83_macros.svh"

module irq_flags (
	input logic clk,
	input logic rst_n,
	input sm83_pkg::byte_t data_in,
	input sm83_pkg::addr_t addr,
	input logic mem_wr,
	input sm83_pkg::irq_mask_t irq_trig,
	output logic ie_sel,
	irq_bus_if.flags irq
);

	import sm83_pkg::*;

	byte_t ie_reg; // Interrupt enable
	irq_mask_t if_reg; // Interrupt request flags
	irq_mask_t ie_mask; // IE bits that map to a source
	irq_mask_t if_set;
	irq_mask_t if_clr;

	assign ie_sel = (addr == `SM83_IE_ADDR); // IE decode
	assign ie_mask = ie_reg[`SM83_IRQ_LINES-1:0];

	// Only enabled sources can raise a flag
	assign if_set = irq_trig & ie_mask;
	assign if_clr = irq.take ? irq.ack : '0; // Acked flag drops on jump

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ie_reg <= '0;
		end else if (mem_wr && ie_sel) begin
			ie_reg <= data_in;
		end
	end

	// Set wins over clear on the same bit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_reg <= '0;
		end else begin
			if_reg <= (if_reg & ~if_clr) | if_set;
		end
	end

	assign irq.pending = if_reg & ie_mask;
	assign irq.ie_q = ie_reg;

endmodule

`default_nettype wire

/* hw/sm83_addr_irq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sm83_macros.svh"

module sm83_addr_irq (
	input logic clk,
	input logic rst_n,
	input sm83_pkg::addr_op_t op,
	input sm83_pkg::byte_t data_in,
	input sm83_pkg::dout_sel_t dout_sel,
	input logic mem_wr,
	input sm83_pkg::irq_mask_t irq_trig,
	input logic ime,
	input logic irq_enable,
	output sm83_pkg::addr_t addr,
	output sm83_pkg::byte_t data_out,
	output logic ie_sel,
	output sm83_pkg::irq_mask_t irq_ack,
	output logic irq_pending
);

	import sm83_pkg::*;

	// Interrupt state shared by the three blocks
	irq_bus_if irq_bus ();

	// IE and IF registers
	irq_flags u_irq_flags (
		.clk(clk),
		.rst_n(rst_n),
		.data_in(data_in),
		.addr(addr), // Decoded for IE writes
		.mem_wr(mem_wr),
		.irq_trig(irq_trig),
		.ie_sel(ie_sel),
		.irq(irq_bus.flags)
	);

	// PC, SP and address register
	addr_unit u_addr_unit (
		.clk(clk),
		.rst_n(rst_n),
		.op(op),
		.data_in(data_in),
		.dout_sel(dout_sel),
		.addr(addr),
		.data_out(data_out),
		.irq(irq_bus.addr)
	);

	// Priority encoder, vector back to addr_unit
	irq_dispatch u_irq_dispatch (
		.ime(ime),
		.irq_enable(irq_enable),
		.irq_pending(irq_pending),
		.irq_ack(irq_ack),
		.irq(irq_bus.dispatch)
	);

endmodule

`default_nettype wire

/* hw/sm83_macros.svh */
`ifndef SM83_MACROS_SVH
`define SM83_MACROS_SVH

// Interrupt sources handled by IE, IF and the dispatch encoder
`define SM83_IRQ_LINES 8

// IE sits at the top of the address space
`define SM83_IE_ADDR 16'hFFFF

// Vector of source n is BASE + n * STRIDE
`define SM83_VECTOR_BASE 16'h0040
`define SM83_VECTOR_STRIDE 16'h0008

// Register state after rst_n
`define SM83_RESET_PC 16'h0000
`define SM83_RESET_SP 16'hFFFE

// Byte lanes of a 16-bit address
`define SM83_LO_BYTE 7:0
`define SM83_HI_BYTE 15:8

`endif

/* hw/sm83_pkg.sv */
`default_nettype none

`include "sm83_macros.svh"

package sm83_pkg;

	typedef logic [7:0] byte_t; // Internal data bus
	typedef logic [15:0] addr_t; // External address bus
	typedef logic [`SM83_IRQ_LINES-1:0] irq_mask_t; // One bit per source

	// Nine ops, so the code needs four bits
	typedef enum logic [3:0] {
		ADDR_NOP = 4'd0,
		ADDR_PC_FETCH = 4'd1, // addr <= PC, PC + 1
		ADDR_SP_PUSH = 4'd2, // SP - 1, addr <= new SP
		ADDR_SP_POP = 4'd3, // addr <= SP, SP + 1
		ADDR_LOAD_PCL = 4'd4,
		ADDR_LOAD_PCH = 4'd5,
		ADDR_LOAD_SPL = 4'd6,
		ADDR_LOAD_SPH = 4'd7,
		ADDR_IRQ_JUMP = 4'd8 // PC <= dispatch vector
	} addr_op_t;

	typedef enum logic [2:0] {
		DOUT_PCL = 3'd0,
		DOUT_PCH = 3'd1,
		DOUT_SPL = 3'd2,
		DOUT_SPH = 3'd3,
		DOUT_IE = 3'd4
	} dout_sel_t;

endpackage

`default_nettype wire

/* sm83_addr_irq.f */
+incdir+hw
hw/sm83_pkg.sv
hw/irq_bus_if.sv
hw/irq_flags.sv
hw/irq_dispatch.sv
hw/addr_unit.sv
hw/sm83_addr_irq.sv
testbench/tb_clock_gen.sv
testbench/sm83_addr_irq_sva.sv
testbench/tb_sm83_addr_irq.sv

/* testbench/sm83_addr_irq_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sm83_macros.svh"

module sm83_addr_irq_sva (
	input logic clk,
	input logic rst_n,
	input logic ime,
	input sm83_pkg::irq_mask_t irq_trig,
	input sm83_pkg::addr_t addr,
	input logic ie_sel,
	input sm83_pkg::irq_mask_t irq_ack,
	input logic irq_pending
);

	logic trig_seen; // Any trigger since reset

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			trig_seen <= 1'b0;
		end else if (|irq_trig) begin
			trig_seen <= 1'b1;
		end
	end

	ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(irq_ack))
		else $error("irq_ack has more than one bit set");

	ack_needs_ime: assert property (@(posedge clk) disable iff (!rst_n) !ime |-> irq_ack == '0)
		else $error("irq_ack active while ime is low");

	ie_decode: assert property (@(posedge clk) disable iff (!rst_n)
		ie_sel == (addr == `SM83_IE_ADDR))
		else $error("ie_sel does not follow the IE address");

	// IF only fills from triggers
	quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!trig_seen |-> !irq_pending)
		else $error("irq_pending rose before any trigger");

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk; // 4 ns period

	// Reset held over two rising edges, released off the edge
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/tb_sm83_addr_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sm83_addr_irq;

	import sm83_pkg::*;

	typedef struct packed {
		addr_t pc;
		addr_t sp;
		addr_t addr;
		byte_t ie;
		irq_mask_t flags;
	} model_t;

	logic clk;
	logic rst_n;
	addr_op_t op;
	byte_t data_in;
	dout_sel_t dout_sel;
	logic mem_wr;
	irq_mask_t irq_trig;
	logic ime;
	logic irq_enable;
	addr_t addr;
	byte_t data_out;
	logic ie_sel;
	irq_mask_t irq_ack;
	logic irq_pending;

	model_t mdl; // Expected register state
	logic [31:0] lfsr_q;
	string test_name;
	int checks;
	int mismatches;
	int timeouts;

	tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

	sm83_addr_irq UUT (
		.clk(clk),
		.rst_n(rst_n),
		.op(op),
		.data_in(data_in),
		.dout_sel(dout_sel),
		.mem_wr(mem_wr),
		.irq_trig(irq_trig),
		.ime(ime),
		.irq_enable(irq_enable),
		.addr(addr),
		.data_out(data_out),
		.ie_sel(ie_sel),
		.irq_ack(irq_ack),
		.irq_pending(irq_pending)
	);

	bind sm83_addr_irq sm83_addr_irq_sva u_sva (
		.clk(clk),
		.rst_n(rst_n),
		.ime(ime),
		.irq_trig(irq_trig),
		.addr(addr),
		.ie_sel(ie_sel),
		.irq_ack(irq_ack),
		.irq_pending(irq_pending)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Lowest pending source wins only with ime and the dispatch enable
	function automatic irq_mask_t pick_winner(input model_t s, input logic ime_i,
			input logic en_i);
		irq_mask_t pend;
		pend = s.flags & s.ie;
		if (ime_i && en_i) begin
			for (int i = 0; i < 8; i++) begin
				if (pend[i]) begin
					return irq_mask_t'(1 << i);
				end
			end
		end
		return '0;
	endfunction

	function automatic addr_t vector_for(input irq_mask_t ack);
		addr_t v;
		v = 16'h0040; // No winner keeps the base
		for (int i = 0; i < 8; i++) begin
			if (ack[i]) begin
				v = 16'h0040 + 16'(8 * i);
			end
		end
		return v;
	endfunction

	function automatic model_t step_model(input model_t s, input addr_op_t op_i, input byte_t din,
			input logic wr, input irq_mask_t trig, input logic ime_i, input logic en_i);
		model_t n;
		irq_mask_t ack;
		n = s;
		ack = pick_winner(s, ime_i, en_i);
		case (op_i)
			ADDR_PC_FETCH: begin
				n.addr = s.pc;
				n.pc = s.pc + 16'd1;
			end
			ADDR_SP_PUSH: begin
				n.sp = s.sp - 16'd1;
				n.addr = s.sp - 16'd1;
			end
			ADDR_SP_POP: begin
				n.addr = s.sp;
				n.sp = s.sp + 16'd1;
			end
			ADDR_LOAD_PCL: n.pc[7:0] = din;
			ADDR_LOAD_PCH: n.pc[15:8] = din;
			ADDR_LOAD_SPL: n.sp[7:0] = din;
			ADDR_LOAD_SPH: n.sp[15:8] = din;
			ADDR_IRQ_JUMP: begin
				n.pc = vector_for(ack);
				n.flags = s.flags & ~ack;
			end
			default: n.pc = s.pc;
		endcase
		if (wr && s.addr == 16'hFFFF) begin
			n.ie = din;
		end
		n.flags = n.flags | (trig & s.ie); // Set after clear
		return n;
	endfunction

	function automatic byte_t readback_byte(input model_t s, input dout_sel_t sel);
		case (sel)
			DOUT_PCL: return s.pc[7:0];
			DOUT_PCH: return s.pc[15:8];
			DOUT_SPL: return s.sp[7:0];
			DOUT_SPH: return s.sp[15:8];
			DOUT_IE: return s.ie;
			default: return 8'h00;
		endcase
	endfunction

	task automatic take_bits(input int n, output logic [7:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[6:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	task automatic drive(input addr_op_t op_i, input byte_t din, input dout_sel_t sel,
			input logic wr, input irq_mask_t trig, input logic ime_i, input logic en_i);
		@(posedge clk);
		#1;
		op = op_i;
		data_in = din;
		dout_sel = sel;
		mem_wr = wr;
		irq_trig = trig;
		ime = ime_i;
		irq_enable = en_i;
	endtask

	task automatic check_val(input string what, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			mismatches++;
			$display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	// Pop from SP FFFF puts FFFF on addr before the IE write
	task automatic write_ie(input byte_t val);
		drive(ADDR_LOAD_SPL, 8'hFF, DOUT_SPL, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_LOAD_SPH, 8'hFF, DOUT_SPH, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_SP_POP, 8'h00, DOUT_SPL, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_NOP, val, DOUT_IE, 1'b1, '0, 1'b0, 1'b0);
		drive(ADDR_NOP, 8'h00, DOUT_IE, 1'b0, '0, 1'b0, 1'b0);
	endtask

	task automatic wait_pending();
		int n;
		logic [7:0] r;
		n = 0;
		@(negedge clk);
		while (!irq_pending && n < 16) begin
			take_bits(8, r);
			drive(ADDR_NOP, 8'h00, DOUT_PCL, 1'b0, r, 1'b1, 1'b1);
			@(negedge clk);
			n++;
		end
		if (!irq_pending) begin
			timeouts++;
			$display("Timeout: irq_pending stayed low for 16 cycles of triggers");
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			mdl.pc = 16'h0000;
			mdl.sp = 16'hFFFE;
			mdl.addr = 16'h0000;
			mdl.ie = 8'h00;
			mdl.flags = 8'h00;
		end else begin
			mdl = step_model(mdl, op, data_in, mem_wr, irq_trig, ime, irq_enable);
		end
	end

	// Compare at mid-cycle where inputs and registers have settled
	always @(negedge clk) begin
		if (rst_n) begin
			check_val("addr", mdl.addr, addr);
			check_val("data_out", 16'(readback_byte(mdl, dout_sel)), 16'(data_out));
			check_val("ie_sel", 16'(mdl.addr == 16'hFFFF), 16'(ie_sel));
			check_val("irq_ack", 16'(pick_winner(mdl, ime, irq_enable)), 16'(irq_ack));
			check_val("irq_pending", 16'(|(mdl.flags & mdl.ie)), 16'(irq_pending));
		end
	end

	initial begin
		int n;
		logic [7:0] r;
		logic [7:0] r2;
		logic [7:0] r3;
		irq_mask_t hit;
		op = ADDR_NOP;
		data_in = '0;
		dout_sel = DOUT_SPL;
		mem_wr = 1'b0;
		irq_trig = '0;
		ime = 1'b0;
		irq_enable = 1'b0;
		lfsr_q = 32'hfa6e;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		test_name = "reset";
		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			timeouts++;
			$display("Timeout: reset was not released within 20 cycles");
		end
		drive(ADDR_NOP, 8'h00, DOUT_SPL, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_NOP, 8'h00, DOUT_SPH, 1'b0, '0, 1'b0, 1'b0);

		test_name = "load_step";
		drive(ADDR_LOAD_PCL, 8'hFE, DOUT_PCL, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_LOAD_PCH, 8'hFF, DOUT_PCH, 1'b0, '0, 1'b0, 1'b0);
		repeat (3) drive(ADDR_PC_FETCH, 8'h00, DOUT_PCL, 1'b0, '0, 1'b0, 1'b0); // Wraps to 0000
		drive(ADDR_LOAD_SPL, 8'h01, DOUT_SPL, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_LOAD_SPH, 8'h00, DOUT_SPH, 1'b0, '0, 1'b0, 1'b0);
		repeat (3) drive(ADDR_SP_PUSH, 8'h00, DOUT_SPL, 1'b0, '0, 1'b0, 1'b0); // Down past 0000
		repeat (3) drive(ADDR_SP_POP, 8'h00, DOUT_SPH, 1'b0, '0, 1'b0, 1'b0);

		test_name = "random_ops";
		repeat (40) begin
			take_bits(3, r);
			take_bits(8, r2);
			drive(addr_op_t'(r[3:0]), r2, dout_sel_t'(3'(r2 % 8'd5)), 1'b0, '0, 1'b0, 1'b0);
		end

		test_name = "ie_write";
		write_ie(8'h1F);
		drive(ADDR_LOAD_PCL, 8'h34, DOUT_IE, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_LOAD_PCH, 8'h12, DOUT_IE, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_PC_FETCH, 8'h00, DOUT_IE, 1'b0, '0, 1'b0, 1'b0);
		drive(ADDR_NOP, 8'hA0, DOUT_IE, 1'b1, '0, 1'b0, 1'b0); // Write at 1234 leaves IE alone
		drive(ADDR_NOP, 8'h00, DOUT_IE, 1'b0, '0, 1'b0, 1'b0);

		test_name = "irq_flags";
		repeat (24) begin
			take_bits(8, r);
			take_bits(8, r2);
			take_bits(2, r3);
			drive(ADDR_NOP, 8'h00, DOUT_IE, 1'b0, r & r2, r3[0], r3[1]);
		end
		write_ie(8'hFF); // Bits 5 to 7 never latched

		test_name = "irq_jump";
		for (int k = 0; k < 6; k++) begin
			wait_pending();
			drive(ADDR_NOP, 8'h00, DOUT_PCL, 1'b0, '0, 1'b1, 1'b1);
			@(negedge clk);
			hit = (k == 3) ? pick_winner(mdl, 1'b1, 1'b1) : '0; // Retrigger the acked bit
			drive(ADDR_IRQ_JUMP, 8'h00, DOUT_PCL, 1'b0, hit, k != 5, 1'b1);
			drive(ADDR_PC_FETCH, 8'h00, DOUT_PCH, 1'b0, '0, 1'b1, 1'b1);
			drive(ADDR_NOP, 8'h00, DOUT_PCL, 1'b0, '0, 1'b1, 1'b1);
		end

		drive(ADDR_NOP, 8'h00, DOUT_PCL, 1'b0, '0, 1'b0, 1'b0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		#1;
		$display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
